// File: all.f
+incdir+include
verilog/phy_mgmt_pkg.sv
verilog/phy_strap_init.sv
verilog/mdio_master.sv
verilog/phy_mgmt_apb.sv
verilog/gige_phy_mgmt_top.sv
dv/gige_phy_mgmt_sva.sv
dv/tb_gige_phy_mgmt.sv

// File: Makefile
# Verilator build and run for the PHY management block

TB_TOP = tb_gige_phy_mgmt

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f all.f --top-module $(TB_TOP) \
		--Mdir obj_dir -o sim
	./obj_dir/sim | tee sim.log
	grep -q "all tests passed" sim.log

lint:
	verilator --lint-only --timing -f all.f --top-module $(TB_TOP)

clean:
	rm -rf obj_dir sim.log

// File: dv/tb_gige_phy_mgmt.sv
//##########################################################
// GigE PHY management testbench
// Directed tests over APB with a behavioural MDIO PHY
//##########################################################
`timescale 1ns/1ns
`include "phy_mgmt_params.svh"

module tb_gige_phy_mgmt import phy_mgmt_pkg::*; ();

	localparam int CLK_NS       = 20;
	// 64 MDC periods of two half periods each
	localparam int FRAME_CYCLES = 64 * 2 * `MDC_HALF_DIV;
	localparam int WATCHDOG_NS  = (16 + `PHY_STRAP_DELAY + 8 * FRAME_CYCLES + 3000) * CLK_NS;

	logic        clk_50;
	logic        reset_n;
	logic [3:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        phy_rst_n;
	logic        strap_oe;
	logic [3:0]  strap_mode;
	logic        strap_clk125;
	logic [4:0]  strap_addr;
	logic        mdc;
	logic        mdio_out;
	logic        mdio_oe;
	logic        mdio_in;

	int          errors;
	int          checks;
	logic [31:0] lfsr;
	logic [15:0] exp_regs [32];
	// PHY model state
	logic [15:0] phy_regs [32];
	logic [1:0]  phy_st;
	logic [1:0]  phy_op;
	logic [4:0]  phy_ad;
	logic [4:0]  phy_reg;
	logic [1:0]  phy_ta;
	int          frame_cnt;
	// Strap monitor results
	int          rst_low_cycles;
	int          oe_cycles;
	int          strap_bad;
	int          mdc_early;
	logic        strap_released;

	// Line as the PHY sees it with a pull-up when nobody drives
	wire mdio_line = mdio_oe ? mdio_out : mdio_in;

	gige_phy_mgmt_top i_gige_phy_mgmt_top (.*);

	initial begin
		clk_50 = 1'b0;
		forever #(CLK_NS / 2) clk_50 = ~clk_50;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within the watchdog limit");
		$display("tests failed");
		$finish;
	end

	task automatic expect_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns %s: got %h expected %h", $time, what, got, exp);
		end
	endtask

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
	function automatic logic [15:0] next_random_word();
		logic        fb;
		logic [15:0] w;
		w = 16'd0;
		for (int i = 0; i < 16; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			w    = {w[14:0], fb};
		end
		return w;
	endfunction

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
		@(posedge clk_50);
		#2;
		psel   = 1'b1;
		pwrite = 1'b1;
		paddr  = addr;
		pwdata = data;
		@(posedge clk_50);
		#2;
		penable = 1'b1;
		@(negedge clk_50);
		err = pslverr;
		expect_value("APB write pready", pready, 32'd1);
		@(posedge clk_50);
		#2;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
		@(posedge clk_50);
		#2;
		psel   = 1'b1;
		pwrite = 1'b0;
		paddr  = addr;
		@(posedge clk_50);
		#2;
		penable = 1'b1;
		@(negedge clk_50);
		data = prdata;
		err  = pslverr;
		expect_value("APB read pready", pready, 32'd1);
		@(posedge clk_50);
		#2;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// Poll STATUS until busy drops
	task automatic wait_frame_end(output logic [31:0] status);
		logic err;
		int   polls;
		polls = 0;
		apb_read(`REG_STATUS, status, err);
		while (status[0] && polls < 2 * FRAME_CYCLES) begin
			apb_read(`REG_STATUS, status, err);
			polls++;
		end
		if (status[0]) begin
			errors++;
			$display("MDIO frame never finished, busy still set at %0t ns", $time);
		end
	endtask

	// Strap pin monitor from reset release until strap_oe drops
	initial begin
		rst_low_cycles = 0;
		oe_cycles      = 0;
		strap_bad      = 0;
		mdc_early      = 0;
		strap_released = 1'b0;
		wait (reset_n === 1'b0);
		while (!strap_released) begin
			@(negedge clk_50);
			if (!phy_rst_n)
				rst_low_cycles++;
			if (mdc)
				mdc_early++;
			if (strap_oe) begin
				oe_cycles++;
				if (strap_mode !== `PHY_STRAP_MODE || strap_clk125 !== `PHY_STRAP_CLK125 ||
				    strap_addr !== `PHY_STRAP_ADDR)
					strap_bad++;
			end else if (oe_cycles > 0) begin
				strap_released = 1'b1;
			end
		end
	end

	// Behavioural PHY that decodes on rising MDC and answers reads after falling MDC
	initial begin
		int          ones;
		logic [12:0] hdr;
		logic [15:0] data;
		frame_cnt = 0;
		for (int i = 0; i < 32; i++)
			phy_regs[i] = 16'hA500 ^ {11'd0, i[4:0]} ^ {i[4:0], 11'd0};
		forever begin
			ones = 0;
			// Hunt for 32 ones and the ST zero
			forever begin
				@(posedge mdc);
				if (mdio_line)
					ones++;
				else if (ones >= 32)
					break;
				else
					ones = 0;
			end
			for (int i = 0; i < 13; i++) begin
				@(posedge mdc);
				hdr = {hdr[11:0], mdio_line};
			end
			phy_st  = {1'b0, hdr[12]};
			phy_op  = hdr[11:10];
			phy_ad  = hdr[9:5];
			phy_reg = hdr[4:0];
			frame_cnt++;
			if (phy_op == MDIO_OP_READ) begin
				// First TA bit stays with the master
				@(negedge mdc);
				@(negedge mdc);
				#1 mdio_in = 1'b0;
				for (int i = 15; i >= 0; i--) begin
					@(negedge mdc);
					#1 mdio_in = phy_regs[phy_reg][i];
				end
				@(negedge mdc);
				#1 mdio_in = 1'b1;
			end else begin
				@(posedge mdc);
				phy_ta[1] = mdio_line;
				@(posedge mdc);
				phy_ta[0] = mdio_line;
				for (int i = 0; i < 16; i++) begin
					@(posedge mdc);
					data = {data[14:0], mdio_line};
				end
				if (phy_ad == `PHY_STRAP_ADDR && phy_op == MDIO_OP_WRITE)
					phy_regs[phy_reg] = data;
			end
		end
	end

	// WDATA, unmapped access and refused CTRL before ready
	task automatic test_register_access();
		logic [31:0] rd;
		logic        err;
		int          mdc_seen;
		apb_write(`REG_WDATA, 32'h0000_BEEF, err);
		expect_value("WDATA write pslverr", err, 0);
		apb_read(`REG_WDATA, rd, err);
		expect_value("WDATA readback", rd, 32'h0000_BEEF);
		apb_read(4'h1, rd, err);
		expect_value("unmapped read pslverr", err, 1);
		apb_read(`REG_STATUS, rd, err);
		expect_value("STATUS before ready", rd, 32'h0);
		apb_write(`REG_CTRL, 32'h0000_0003, err);
		expect_value("CTRL before ready pslverr", err, 1);
		mdc_seen = 0;
		repeat (100) begin
			@(negedge clk_50);
			if (mdc)
				mdc_seen++;
		end
		expect_value("MDC activity after refused CTRL", mdc_seen, 0);
	endtask

	task automatic test_strap_sequence();
		logic [31:0] rd;
		logic        err;
		int          waited;
		waited = 0;
		while (!strap_released && waited < `PHY_STRAP_DELAY + 200) begin
			@(negedge clk_50);
			waited++;
		end
		if (!strap_released) begin
			errors++;
			$display("Straps were never released at %0t ns", $time);
		end
		expect_value("phy_rst_n low cycles", rst_low_cycles, 1);
		expect_value("strap_oe high cycles", oe_cycles, `PHY_STRAP_DELAY + 1);
		expect_value("strap value mismatches", strap_bad, 0);
		expect_value("MDC activity before ready", mdc_early, 0);
		apb_read(`REG_STATUS, rd, err);
		expect_value("STATUS after ready", rd, 32'h2);
	endtask

	task automatic test_mdio_write(input logic [4:0] addr);
		logic [31:0] st;
		logic        err;
		exp_regs[addr] = next_random_word();
		apb_write(`REG_WDATA, {16'd0, exp_regs[addr]}, err);
		apb_write(`REG_CTRL, {27'd0, addr}, err);
		expect_value("CTRL write pslverr", err, 0);
		wait_frame_end(st);
		expect_value("STATUS after write", st, 32'h6);
		expect_value("PHY saw ST", phy_st, 2'b01);
		expect_value("PHY saw OP", phy_op, 2'b01);
		expect_value("PHY saw PHYAD", phy_ad, `PHY_STRAP_ADDR);
		expect_value("PHY saw REGAD", phy_reg, addr);
		expect_value("PHY saw TA", phy_ta, 2'b10);
		expect_value("PHY register contents", phy_regs[addr], exp_regs[addr]);
	endtask

	task automatic test_mdio_read(input logic [4:0] addr);
		logic [31:0] st;
		logic [31:0] rd;
		logic        err;
		apb_write(`REG_CTRL, {23'd0, 1'b1, 3'd0, addr}, err);
		expect_value("CTRL read pslverr", err, 0);
		wait_frame_end(st);
		expect_value("STATUS after read", st, 32'h6);
		expect_value("PHY saw read OP", phy_op, 2'b10);
		expect_value("PHY saw read REGAD", phy_reg, addr);
		apb_read(`REG_RDATA, rd, err);
		expect_value("RDATA", rd, {16'd0, exp_regs[addr]});
	endtask

	// Second CTRL write during a frame is refused
	task automatic test_back_pressure();
		logic [31:0] st;
		logic        err;
		int          frames;
		int          mdc_seen;
		exp_regs[17] = next_random_word();
		frames       = frame_cnt;
		apb_write(`REG_WDATA, {16'd0, exp_regs[17]}, err);
		apb_write(`REG_CTRL, 32'd17, err);
		expect_value("first CTRL pslverr", err, 0);
		apb_write(`REG_CTRL, 32'd3, err);
		expect_value("CTRL while busy pslverr", err, 1);
		wait_frame_end(st);
		expect_value("frames after back-pressure", frame_cnt, frames + 1);
		expect_value("running frame REGAD", phy_reg, 5'd17);
		expect_value("running frame data", phy_regs[17], exp_regs[17]);
		mdc_seen = 0;
		repeat (300) begin
			@(negedge clk_50);
			if (mdc)
				mdc_seen++;
		end
		expect_value("MDC activity after frame", mdc_seen, 0);
		expect_value("no extra frame", frame_cnt, frames + 1);
	endtask

	initial begin
		errors  = 0;
		checks  = 0;
		lfsr    = 32'd80289;
		reset_n = 1'b1;
		paddr   = 4'd0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = 32'd0;
		mdio_in = 1'b1;
		repeat (16) @(posedge clk_50);
		expect_value("phy_rst_n in reset", phy_rst_n, 1);
		expect_value("strap_oe in reset", strap_oe, 0);
		expect_value("mdc in reset", mdc, 0);
		expect_value("mdio_oe in reset", mdio_oe, 0);
		#2 reset_n = 1'b0;
		test_register_access();
		test_strap_sequence();
		test_mdio_write(5'd0);
		test_mdio_write(5'd9);
		test_mdio_write(5'd31);
		test_mdio_read(5'd0);
		test_mdio_read(5'd9);
		test_mdio_read(5'd31);
		test_back_pressure();
		$display("errors: %0d of %0d checks", errors, checks);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: dv/gige_phy_mgmt_sva.sv
//##########################################################
// PHY management assertions
// Strap release and MDIO pin rules, bound into the top level
//##########################################################
`timescale 1ns/1ns

module gige_phy_mgmt_sva import phy_mgmt_pkg::*; (
	input logic         clk_50,
	input logic         reset_n,
	input strap_state_e strap_state,
	input logic         strap_oe,
	input mdio_state_e  md_state,
	input mdio_op_e     md_op,
	input logic         mdio_oe,
	input logic         mdc,
	input logic         start,
	input logic         busy
);

	// Straps released once the PHY is ready
	a_strap_released: assert property (@(posedge clk_50) disable iff (reset_n)
		strap_state == ST_READY |-> !strap_oe)
		else $error("strap_oe high in ST_READY");

	// PHY owns the line during read data
	a_read_released: assert property (@(posedge clk_50) disable iff (reset_n)
		(md_state == MD_DATA && md_op == MDIO_OP_READ) |-> !mdio_oe)
		else $error("mdio_oe high during read data");

	// MDC parked low between frames
	a_mdc_idle: assert property (@(posedge clk_50) disable iff (reset_n)
		md_state == MD_IDLE |-> (!mdc && $stable(mdc)))
		else $error("mdc moved while idle");

	// APB block only launches an idle engine
	a_start_idle: assert property (@(posedge clk_50) disable iff (reset_n)
		start |-> !busy)
		else $error("start while busy");

endmodule

bind gige_phy_mgmt_top gige_phy_mgmt_sva i_gige_phy_mgmt_sva (
	.clk_50      (clk_50),
	.reset_n     (reset_n),
	.strap_state (i_phy_strap_init.state),
	.strap_oe    (strap_oe),
	.md_state    (i_mdio_master.state),
	.md_op       (i_mdio_master.op_q),
	.mdio_oe     (mdio_oe),
	.mdc         (mdc),
	.start       (start),
	.busy        (busy)
);

// File: verilog/gige_phy_mgmt_top.sv
//##########################################################
// GigE PHY management top level
// Strap sequencer, MDIO master and APB registers
//##########################################################
`timescale 1ns/1ns
`include "phy_mgmt_params.svh"

module gige_phy_mgmt_top import phy_mgmt_pkg::*; (
	input  logic                   clk_50,
	input  logic                   reset_n,
	// APB
	input  logic [`APB_ADDR_W-1:0] paddr,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,
	// PHY reset and straps
	output logic                   phy_rst_n,
	output logic                   strap_oe,
	output logic [3:0]             strap_mode,
	output logic                   strap_clk125,
	output logic [4:0]             strap_addr,
	// MDIO, split tristate
	output logic                   mdc,
	output logic                   mdio_out,
	output logic                   mdio_oe,
	input  logic                   mdio_in
);

	logic        phy_ready;
	logic        start;
	logic        busy;
	logic        done;
	mdio_op_e    op;
	logic [4:0]  reg_addr;
	logic [15:0] wr_data;
	logic [15:0] rd_data;

	phy_strap_init i_phy_strap_init (
		.clk_50       (clk_50),
		.reset_n      (reset_n),
		.phy_rst_n    (phy_rst_n),
		.strap_oe     (strap_oe),
		.strap_mode   (strap_mode),
		.strap_clk125 (strap_clk125),
		.strap_addr   (strap_addr),
		.phy_ready    (phy_ready)
	);

	mdio_master i_mdio_master (
		.clk_50   (clk_50),
		.reset_n  (reset_n),
		.start    (start),
		.op       (op),
		.reg_addr (reg_addr),
		.wr_data  (wr_data),
		.busy     (busy),
		.done     (done),
		.rd_data  (rd_data),
		.mdc      (mdc),
		.mdio_out (mdio_out),
		.mdio_oe  (mdio_oe),
		.mdio_in  (mdio_in)
	);

	phy_mgmt_apb i_phy_mgmt_apb (
		.clk_50    (clk_50),
		.reset_n   (reset_n),
		.paddr     (paddr),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.phy_ready (phy_ready),
		.busy      (busy),
		.done      (done),
		.rd_data   (rd_data),
		.start     (start),
		.op        (op),
		.reg_addr  (reg_addr),
		.wr_data   (wr_data)
	);

endmodule

// File: verilog/phy_mgmt_apb.sv
//##########################################################
// PHY management APB register block
// CTRL, WDATA, RDATA and STATUS, launches MDIO frames
//##########################################################
`timescale 1ns/1ns
`include "phy_mgmt_params.svh"

module phy_mgmt_apb import phy_mgmt_pkg::*; (
	input  logic                   clk_50,
	input  logic                   reset_n,
	input  logic [`APB_ADDR_W-1:0] paddr,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,
	input  logic                   phy_ready,
	input  logic                   busy,
	input  logic                   done,
	input  logic [15:0]            rd_data,
	output logic                   start,
	output mdio_op_e               op,
	output logic [4:0]             reg_addr,
	output logic [15:0]            wr_data
);

	logic        access;
	logic        wr_access;
	logic        hit_ctrl;
	logic        hit_wdata;
	logic        hit_rdata;
	logic        hit_status;
	logic        mapped;
	logic        frame_active;
	logic        ctrl_refused;
	logic        ctrl_accept;
	logic [15:0] wdata_q;
	logic [15:0] rdata_q;
	// Sticky done flag
	logic        done_q;

	// Zero wait states, access phase is the only cycle that counts
	assign access    = psel && penable;
	assign wr_access = access && pwrite;
	assign pready    = 1'b1;

	// Address decode
	assign hit_ctrl   = (paddr == `REG_CTRL);
	assign hit_wdata  = (paddr == `REG_WDATA);
	assign hit_rdata  = (paddr == `REG_RDATA);
	assign hit_status = (paddr == `REG_STATUS);
	assign mapped     = hit_ctrl || hit_wdata || hit_rdata || hit_status;

	// Start counts as busy until the engine picks it up
	assign frame_active = busy || start;
	assign ctrl_refused = hit_ctrl && (frame_active || !phy_ready);
	assign ctrl_accept  = wr_access && hit_ctrl && !ctrl_refused;
	assign pslverr      = access && (!mapped || (pwrite && ctrl_refused));

	assign wr_data = wdata_q;

	// One-cycle start pulse
	always_ff @(posedge clk_50) begin
		if (reset_n) begin
			start <= 1'b0;
		end else begin
			start <= ctrl_accept;
		end
	end

	// Frame fields from CTRL, bit 8 picks read
	always_ff @(posedge clk_50) begin
		if (ctrl_accept) begin
			reg_addr <= pwdata[4:0];
			op       <= pwdata[8] ? MDIO_OP_READ : MDIO_OP_WRITE;
		end
	end

	// WDATA register
	always_ff @(posedge clk_50) begin
		if (wr_access && hit_wdata) begin
			wdata_q <= pwdata[15:0];
		end
	end

	// Keep the result of read frames only
	always_ff @(posedge clk_50) begin
		if (done && op == MDIO_OP_READ) begin
			rdata_q <= rd_data;
		end
	end

	// Done set by engine, cleared by next start
	always_ff @(posedge clk_50) begin
		if (reset_n) begin
			done_q <= 1'b0;
		end else if (start) begin
			done_q <= 1'b0;
		end else if (done) begin
			done_q <= 1'b1;
		end
	end

	// Read mux
	always_comb begin
		prdata = 32'd0;
		if (psel && !pwrite) begin
			case (paddr)
			`REG_CTRL:   prdata = {23'd0, op == MDIO_OP_READ, 3'd0, reg_addr};
			`REG_WDATA:  prdata = {16'd0, wdata_q};
			`REG_RDATA:  prdata = {16'd0, rdata_q};
			`REG_STATUS: prdata = {29'd0, done_q, phy_ready, frame_active};
			default:     prdata = 32'd0;
			endcase
		end
	end

endmodule

// File: verilog/mdio_master.sv
//##########################################################
// Clause-22 MDIO master
// MDC divider, frame serializer and read data capture
//##########################################################
`timescale 1ns/1ns
`include "phy_mgmt_params.svh"

module mdio_master import phy_mgmt_pkg::*; (
	input  logic        clk_50,
	input  logic        reset_n,
	input  logic        start,
	input  mdio_op_e    op,
	input  logic [4:0]  reg_addr,
	input  logic [15:0] wr_data,
	output logic        busy,
	output logic        done,
	output logic [15:0] rd_data,
	output logic        mdc,
	output logic        mdio_out,
	output logic        mdio_oe,
	input  logic        mdio_in
);

	mdio_state_e state;
	mdio_op_e    op_q;
	logic [3:0]  div_cnt;
	logic        running;
	logic        half_end;
	logic        rise_tick;
	logic        fall_tick;
	// Index of the bit currently on the line, 0..63
	logic [5:0]  bit_cnt;
	logic [5:0]  next_bit;
	// ST, OP, PHYAD, REGAD, TA, DATA
	logic [31:0] frame_sh;
	logic [1:0]  ta_bits;

	assign running   = state inside {MD_PREAMBLE, MD_HEADER, MD_TURNAROUND, MD_DATA};
	assign half_end  = running && (div_cnt == `MDC_HALF_DIV - 4'd1);
	// MDC is about to toggle, so the tick names the coming edge
	assign rise_tick = half_end && !mdc;
	assign fall_tick = half_end && mdc;
	assign next_bit  = bit_cnt + 6'd1;

	// Busy from the cycle after start through MD_DONE
	assign busy = (state != MD_IDLE);
	assign done = (state == MD_DONE);

	// Write TA is 10, read drives the first TA bit high then releases
	assign ta_bits = (op == MDIO_OP_WRITE) ? 2'b10 : 2'b11;

	// MDC divider, parked low outside a frame
	always_ff @(posedge clk_50) begin
		if (reset_n) begin
			div_cnt <= 4'd0;
			mdc     <= 1'b0;
		end else if (!running) begin
			div_cnt <= 4'd0;
			mdc     <= 1'b0;
		end else if (half_end) begin
			div_cnt <= 4'd0;
			mdc     <= ~mdc;
		end else begin
			div_cnt <= div_cnt + 4'd1;
		end
	end

	// Frame FSM, line updates ride the falling MDC edge
	always_ff @(posedge clk_50) begin
		if (reset_n) begin
			state    <= MD_IDLE;
			bit_cnt  <= 6'd0;
			mdio_out <= 1'b1;
			mdio_oe  <= 1'b0;
		end else begin
			case (state)
			MD_IDLE: begin
				if (start) begin
					// First preamble bit goes out right away
					state    <= MD_PREAMBLE;
					bit_cnt  <= 6'd0;
					mdio_out <= 1'b1;
					mdio_oe  <= 1'b1;
				end
			end
			MD_PREAMBLE, MD_HEADER, MD_TURNAROUND, MD_DATA: begin
				if (fall_tick) begin
					bit_cnt <= next_bit;
					if (bit_cnt == 6'd63) begin
						// 64th MDC period done
						state    <= MD_DONE;
						mdio_oe  <= 1'b0;
						mdio_out <= 1'b1;
					end else begin
						if (next_bit < `MDIO_PREAMBLE_BITS) begin
							mdio_out <= 1'b1;
						end else begin
							mdio_out <= frame_sh[31];
						end
						if (next_bit == `MDIO_PREAMBLE_BITS) begin
							state <= MD_HEADER;
						end
						// ST+OP+PHYAD+REGAD is 14 bits
						if (next_bit == `MDIO_PREAMBLE_BITS + 6'd14) begin
							state <= MD_TURNAROUND;
						end
						if (next_bit == `MDIO_PREAMBLE_BITS + 6'd16) begin
							state <= MD_DATA;
						end
						// PHY owns the line from second TA bit on a read
						if (next_bit == `MDIO_PREAMBLE_BITS + 6'd15 &&
						    op_q == MDIO_OP_READ) begin
							mdio_oe <= 1'b0;
						end
					end
				end
			end
			MD_DONE: begin
				state <= MD_IDLE;
			end
			default: begin
				state <= MD_IDLE;
			end
			endcase
		end
	end

	// Frame shifter, MSB goes out next
	always_ff @(posedge clk_50) begin
		if (state == MD_IDLE && start) begin
			op_q     <= op;
			frame_sh <= {2'b01, op, `PHY_STRAP_ADDR, reg_addr, ta_bits, wr_data};
		end else if (fall_tick && next_bit >= `MDIO_PREAMBLE_BITS) begin
			frame_sh <= {frame_sh[30:0], 1'b0};
		end
	end

	// Read data sampled on rising MDC, MSB first
	always_ff @(posedge clk_50) begin
		if (rise_tick && state == MD_DATA && op_q == MDIO_OP_READ) begin
			rd_data <= {rd_data[14:0], mdio_in};
		end
	end

endmodule

// File: verilog/phy_strap_init.sv
//##########################################################
// PHY strap sequencer
// Pulses PHY hardware reset, drives the config straps,
// holds them for the strap delay and then flags PHY ready
//##########################################################
`timescale 1ns/1ns
`include "phy_mgmt_params.svh"

module phy_strap_init import phy_mgmt_pkg::*; (
	input  logic       clk_50,
	input  logic       reset_n,
	output logic       phy_rst_n,
	output logic       strap_oe,
	output logic [3:0] strap_mode,
	output logic       strap_clk125,
	output logic [4:0] strap_addr,
	output logic       phy_ready
);

	strap_state_e state;
	// Counts clk_50 cycles while straps are held
	logic [12:0]  hold_cnt;

	// Sequencer
	always_ff @(posedge clk_50) begin
		if (reset_n) begin
			state     <= ST_RESET;
			phy_rst_n <= 1'b1;
			strap_oe  <= 1'b0;
			phy_ready <= 1'b0;
			hold_cnt  <= 13'd0;
		end else begin
			case (state)
			ST_RESET: begin
				// Assert PHY reset and take over the strap pins
				phy_rst_n <= 1'b0;
				strap_oe  <= 1'b1;
				state     <= ST_CONFIG;
			end
			ST_CONFIG: begin
				// PHY leaves reset and samples the straps
				phy_rst_n <= 1'b1;
				hold_cnt  <= 13'd0;
				state     <= ST_HOLD;
			end
			ST_HOLD: begin
				hold_cnt <= hold_cnt + 13'd1;
				// Release the pins on the last hold cycle
				if (hold_cnt == `PHY_STRAP_DELAY - 13'd1) begin
					strap_oe <= 1'b0;
					state    <= ST_READY;
				end
			end
			ST_READY: begin
				// Stays ready until the next reset
				phy_ready <= 1'b1;
			end
			default: begin
				state <= ST_RESET;
			end
			endcase
		end
	end

	// Straps carry the header values while driven
	// Pins read as zero while not driven
	assign strap_mode   = strap_oe ? `PHY_STRAP_MODE : 4'd0;
	assign strap_clk125 = strap_oe ? `PHY_STRAP_CLK125 : 1'b0;
	assign strap_addr   = strap_oe ? `PHY_STRAP_ADDR : 5'd0;

endmodule

// File: verilog/phy_mgmt_pkg.sv
//##########################################################
// PHY management types
// State and opcode enums for strap sequencer and MDIO engine
//##########################################################
package phy_mgmt_pkg;

	// Power-up strap sequence
	typedef enum logic [1:0] {
		ST_RESET  = 2'd0,
		ST_CONFIG = 2'd1,
		ST_HOLD   = 2'd2,
		ST_READY  = 2'd3
	} strap_state_e;

	// Clause-22 OP field
	typedef enum logic [1:0] {
		MDIO_OP_WRITE = 2'b01,
		MDIO_OP_READ  = 2'b10
	} mdio_op_e;

	// MDIO frame phases
	typedef enum logic [2:0] {
		MD_IDLE,
		MD_PREAMBLE,
		MD_HEADER,
		MD_TURNAROUND,
		MD_DATA,
		MD_DONE
	} mdio_state_e;

endpackage

// File: include/phy_mgmt_params.svh
//##########################################################
// PHY management constants
// Strap values, strap hold delay, MDC divider, APB register map
//##########################################################
`ifndef PHY_MGMT_PARAMS_SVH
`define PHY_MGMT_PARAMS_SVH

// Strap hold time in clk_50 cycles, 100 us
`define PHY_STRAP_DELAY     13'd5000
// MDIO address strapped into the PHY, also used as PHYAD in every frame
`define PHY_STRAP_ADDR      5'd1
// GMII/MII mode
`define PHY_STRAP_MODE      4'd1
// 125 MHz clock output enable
`define PHY_STRAP_CLK125    1'b1

// clk_50 cycles per MDC half period, MDC at 2.5 MHz
`define MDC_HALF_DIV        4'd10
`define MDIO_PREAMBLE_BITS  6'd32

// APB register map
`define APB_ADDR_W          4
`define REG_CTRL            4'h0
`define REG_WDATA           4'h4
`define REG_RDATA           4'h8
`define REG_STATUS          4'hC

`endif
